//--- bench/mem_pipe_asserts.sv
`default_nettype none

`include "mem_config.svh"

module mem_pipe_asserts
    import mem_common_pkg::*, mem_pipe_pkg::*;
(
    input logic                        clk,
    input logic                        reset,
    input logic [`FLQ_NUM_ENTRIES-1:0] e_busy,
    input t_line_addr                  e_line [`FLQ_NUM_ENTRIES],
    input logic                        alloc,
    input t_pipe_action                mm5_action,
    input t_flq_id                     mm5_entry
);

    logic dup_line;

    always_comb begin
        dup_line = 1'b0;
        for (int i = 0; i < `FLQ_NUM_ENTRIES; i++) begin
            for (int j = i + 1; j < `FLQ_NUM_ENTRIES; j++) begin
                if (e_busy[i] && e_busy[j] && e_line[i] == e_line[j]) begin
                    dup_line = 1'b1;
                end
            end
        end
    end

    no_dup_line_a: assert property (@(posedge clk) disable iff (reset) !dup_line)
        else $error("two busy fill queue entries hold the same line");

    // Allocation needs a free entry
    no_alloc_when_full_a: assert property (@(posedge clk) disable iff (reset)
        alloc |-> !(&e_busy))
        else $error("allocation into a full fill queue");

    // Fill completes only for an entry still waiting on it
    fill_to_busy_entry_a: assert property (@(posedge clk) disable iff (reset)
        (mm5_action == ACT_FILL) |-> e_busy[mm5_entry])
        else $error("fill completed for an idle fill queue entry");

endmodule

`default_nettype wire

//--- bench/mem_pipe_checker.sv
`default_nettype none

`include "mem_config.svh"

module mem_pipe_checker
    import mem_common_pkg::*, mem_pipe_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       req_valid,
    input logic       req_gnt,
    input t_paddr     req_addr,
    input t_req_id    req_id,
    input logic       rsp_valid,
    input logic       rsp_nack,
    input t_req_id    rsp_id,
    input t_word      rsp_data,
    input logic       mem_req_valid,
    input t_line_addr mem_req_line,
    input t_flq_id    mem_req_tag,
    input logic       mem_rsp_valid,
    input t_flq_id    mem_rsp_tag
);

    localparam int IDS = 1 << `REQ_ID_WIDTH;
    localparam int K_HIT = 0;
    localparam int K_MISS = 1;
    localparam int K_NACK = 2;

    int errors = 0;
    int checks = 0;
    int cycle = 0;
    logic [IDS-1:0] pending = '0;
    logic [IDS-1:0] nacked = '0;
    logic [IDS-1:0] mem_seen = '0;
    logic [1:0] kind [IDS];
    int acc_cycle [IDS];
    t_line_addr req_line [IDS];
    logic [(1 << $bits(t_line_addr))-1:0] line_out = '0;
    t_line_addr tag_line [`FLQ_NUM_ENTRIES];
    logic mem_rsp_last = 1'b0;
    logic gnt_live = 1'b0;

    // Memory rule: line address times a constant, plus one
    function automatic t_word line_data(t_line_addr l);
        return t_word'(l) * 32'h9e3779b1 + 32'd1;
    endfunction

    task automatic set_kind(input int id, input logic [1:0] k);
        kind[id] = k;
    endtask

    task automatic report_error(input string msg);
        $display("error t=%0t: %s", $time, msg);
        errors++;
    endtask

    task automatic final_check();
        for (int i = 0; i < IDS; i++) begin
            if (pending[i]) report_error($sformatf("id %0d never answered", i));
        end
    endtask

    always @(negedge clk) begin : watch
        int lat;
        if (!reset) begin
            cycle++;
            if (rsp_valid && rsp_nack) report_error("data response and nack together");
            // A replay is pending only in the cycle after a memory response
            if (gnt_live && req_gnt == mem_rsp_last) begin
                report_error($sformatf("req_gnt %b, replay pending %b", req_gnt, mem_rsp_last));
            end
            mem_rsp_last = mem_rsp_valid;
            gnt_live = 1'b1;
            if (mem_rsp_valid) line_out[tag_line[mem_rsp_tag]] = 1'b0;
            if (mem_req_valid) begin
                if (line_out[mem_req_line]) begin
                    report_error($sformatf("second memory request for line %h", mem_req_line));
                end
                line_out[mem_req_line] = 1'b1;
                tag_line[mem_req_tag] = mem_req_line;
                for (int i = 0; i < IDS; i++) begin
                    if (pending[i] && req_line[i] == mem_req_line) mem_seen[i] = 1'b1;
                end
            end
            if (rsp_valid || rsp_nack) begin
                checks++;
                lat = cycle - acc_cycle[rsp_id];
                if (!pending[rsp_id]) begin
                    report_error($sformatf("response for id %0d with nothing pending", rsp_id));
                end else if (rsp_nack) begin
                    if (kind[rsp_id] == K_HIT || kind[rsp_id] == K_MISS || lat != 5) begin
                        report_error($sformatf("id %0d nack, latency %0d", rsp_id, lat));
                    end
                end else begin
                    if (rsp_data !== line_data(req_line[rsp_id])) begin
                        report_error($sformatf("id %0d data %h expected %h", rsp_id,
                            rsp_data, line_data(req_line[rsp_id])));
                    end
                    if (kind[rsp_id] == K_NACK) begin
                        report_error($sformatf("id %0d answered, nack expected", rsp_id));
                    end
                    if (kind[rsp_id] == K_HIT && (lat != 5 || mem_seen[rsp_id])) begin
                        report_error($sformatf("id %0d not a hit, latency %0d", rsp_id, lat));
                    end
                    if (kind[rsp_id] == K_MISS && (lat <= 5 || !mem_seen[rsp_id])) begin
                        report_error($sformatf("id %0d not a miss, latency %0d", rsp_id, lat));
                    end
                end
                pending[rsp_id] = 1'b0;
                nacked[rsp_id] = rsp_nack;
            end
            if (req_valid && req_gnt) begin
                if (pending[req_id]) report_error($sformatf("id %0d reused in flight", req_id));
                pending[req_id] = 1'b1;
                acc_cycle[req_id] = cycle;
                req_line[req_id] = req_addr[`PADDR_WIDTH-1:`LINE_OFFSET_BITS];
                mem_seen[req_id] = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/mem_pipe_tb.sv
`default_nettype none

`include "mem_config.svh"

module mem_pipe_tb
    import mem_common_pkg::*, mem_pipe_pkg::*;
();

    localparam int ROWS = 20;
    localparam int LIMIT = 40 * ROWS + 200;
    localparam logic [1:0] K_HIT = 2'd0;
    localparam logic [1:0] K_MISS = 2'd1;
    localparam logic [1:0] K_NACK = 2'd2;
    localparam logic [1:0] K_ANY = 2'd3;

    typedef struct packed {
        logic [15:0] addr;
        logic [3:0]  id;
        logic [1:0]  kind;
        logic        retry;
        logic        wait_rsp;
        logic        hold;
    } t_row;

    // addr, id, expected outcome, retry, wait for response, hold memory
    t_row rows [ROWS] = '{
        '{16'h0040, 4'd1, K_MISS, 1'b0, 1'b1, 1'b0},
        '{16'h0044, 4'd2, K_HIT, 1'b0, 1'b1, 1'b0},
        '{16'h0080, 4'd3, K_MISS, 1'b0, 1'b0, 1'b0},
        '{16'h0088, 4'd4, K_NACK, 1'b0, 1'b1, 1'b0},
        '{16'h00c0, 4'd5, K_MISS, 1'b0, 1'b0, 1'b1},
        '{16'h00c4, 4'd6, K_NACK, 1'b0, 1'b1, 1'b1},
        '{16'h00c8, 4'd7, K_NACK, 1'b0, 1'b1, 1'b1},
        '{16'h0100, 4'd8, K_MISS, 1'b0, 1'b0, 1'b1},
        '{16'h0140, 4'd9, K_MISS, 1'b0, 1'b0, 1'b1},
        '{16'h0180, 4'd10, K_NACK, 1'b0, 1'b1, 1'b1},
        '{16'h0048, 4'd11, K_HIT, 1'b0, 1'b1, 1'b0},
        '{16'h0180, 4'd10, K_ANY, 1'b1, 1'b1, 1'b0},
        '{16'h0440, 4'd12, K_MISS, 1'b0, 1'b1, 1'b0},
        '{16'h0040, 4'd13, K_MISS, 1'b0, 1'b1, 1'b0},
        '{16'h0040, 4'd14, K_HIT, 1'b0, 1'b1, 1'b0},
        '{16'h01c0, 4'd15, K_MISS, 1'b0, 1'b0, 1'b0},
        '{16'h0200, 4'd0, K_MISS, 1'b0, 1'b0, 1'b0},
        '{16'h0240, 4'd1, K_MISS, 1'b0, 1'b0, 1'b0},
        '{16'h0050, 4'd2, K_HIT, 1'b0, 1'b0, 1'b0},
        '{16'h0054, 4'd4, K_HIT, 1'b0, 1'b0, 1'b0}
    };

    logic clk, reset, req_valid, req_gnt, rsp_valid, rsp_nack, hold_mem;
    logic mem_req_valid, mem_rsp_valid;
    t_paddr req_addr;
    t_req_id req_id, rsp_id;
    t_word rsp_data, mem_rsp_data;
    t_line_addr mem_req_line;
    t_flq_id mem_req_tag, mem_rsp_tag;
    int cycle = 0;
    logic [31:0] lfsr = 32'h8fd677c9;
    logic mem_pend [`FLQ_NUM_ENTRIES] = '{default: 1'b0};
    t_line_addr mem_line [`FLQ_NUM_ENTRIES];
    int mem_due [`FLQ_NUM_ENTRIES];

    mem_pipe mem_pipe_inst (.*);

    mem_pipe_checker checker_inst (.*);

    bind fillq mem_pipe_asserts mem_pipe_asserts_inst (
        .clk, .reset, .e_busy, .e_line, .alloc, .mm5_action, .mm5_entry
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle > LIMIT) begin
            $display("timeout: the run hung after %0d cycles", cycle);
            $display("Testbench failed");
            $finish;
        end
    end

    // Memory model, one response per cycle, 3 to 10 cycles late
    always @(posedge clk) begin : memory
        int delay;
        logic found;
        logic held;
        // Hold as it stood before this edge
        held = hold_mem;
        #10;
        mem_rsp_valid = 1'b0;
        if (!reset && mem_req_valid) begin
            delay = 3;
            for (int b = 0; b < 3; b++) begin
                delay += int'(lfsr[0]) << b;
                lfsr = lfsr_next(lfsr);
            end
            mem_pend[mem_req_tag] = 1'b1;
            mem_line[mem_req_tag] = mem_req_line;
            mem_due[mem_req_tag] = cycle + delay;
        end
        found = 1'b0;
        for (int e = 0; e < `FLQ_NUM_ENTRIES; e++) begin
            if (!reset && !held && !found && mem_pend[e] && mem_due[e] <= cycle) begin
                found = 1'b1;
                mem_pend[e] = 1'b0;
                mem_rsp_valid = 1'b1;
                mem_rsp_tag = t_flq_id'(e);
                mem_rsp_data = t_word'(mem_line[e]) * 32'h9e3779b1 + 32'd1;
            end
        end
    end

    // Leaves the request up until granted
    task automatic send_req(input t_row row);
        @(posedge clk);
        #10;
        checker_inst.set_kind(row.id, row.kind);
        hold_mem = row.hold;
        req_valid = 1'b1;
        req_addr = row.addr;
        req_id = row.id;
        do @(negedge clk); while (!req_gnt);
    endtask

    task automatic wait_answer(input t_req_id id);
        @(posedge clk);
        #10;
        req_valid = 1'b0;
        while (checker_inst.pending[id]) @(posedge clk);
    endtask

    initial begin
        reset = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_id = '0;
        hold_mem = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_tag = '0;
        mem_rsp_data = '0;
        repeat (2) @(posedge clk);
        #10;
        reset = 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            do begin
                send_req(rows[r]);
                if (rows[r].wait_rsp) wait_answer(rows[r].id);
            end while (rows[r].retry && checker_inst.nacked[rows[r].id]);
            $display("row %0d: addr %h id %0d done, errors so far %0d",
                r, rows[r].addr, rows[r].id, checker_inst.errors);
        end
        @(posedge clk);
        #10;
        req_valid = 1'b0;
        hold_mem = 1'b0;
        while (checker_inst.pending != '0) @(posedge clk);
        repeat (5) @(posedge clk);
        checker_inst.final_check();
        $display("responses checked %0d, errors %0d", checker_inst.checks, checker_inst.errors);
        if (checker_inst.errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/fillq.sv
`default_nettype none

`include "mem_config.svh"

module fillq
    import mem_common_pkg::*, mem_pipe_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         mm3_valid,
    input  t_line_addr   mm3_line,
    input  t_pipe_action mm5_action,
    input  t_line_addr   mm5_line,
    input  t_req_id      mm5_id,
    input  t_flq_id      mm5_entry,
    input  logic         flq_pipe_gnt,
    input  logic         mem_rsp_valid,
    input  t_flq_id      mem_rsp_tag,
    input  t_word        mem_rsp_data,
    output logic         flq_addr_mat_mm4,
    output logic         flq_full,
    output logic         flq_pipe_req,
    output t_line_addr   flq_pipe_line,
    output t_req_id      flq_pipe_id,
    output t_word        flq_pipe_data,
    output t_flq_id      flq_pipe_entry,
    output logic         mem_req_valid,
    output t_line_addr   mem_req_line,
    output t_flq_id      mem_req_tag
);

    logic alloc, cam_mat;
    logic [`FLQ_NUM_ENTRIES-1:0] e_alloc, e_busy, e_mem_req, e_mem_gnt;
    logic [`FLQ_NUM_ENTRIES-1:0] e_pipe_req, e_pipe_sel, e_pipe_gnt, e_rsp_hit, e_fill_done;
    t_line_addr e_line [`FLQ_NUM_ENTRIES];
    t_req_id    e_id [`FLQ_NUM_ENTRIES];
    t_word      e_data [`FLQ_NUM_ENTRIES];

    // Lowest set bit, one-hot
    function automatic logic [`FLQ_NUM_ENTRIES-1:0] find_first(
        input logic [`FLQ_NUM_ENTRIES-1:0] vec
    );
        logic [`FLQ_NUM_ENTRIES-1:0] sel;
        sel = '0;
        for (int i = 0; i < `FLQ_NUM_ENTRIES; i++) begin
            if (vec[i] && sel == '0) sel[i] = 1'b1;
        end
        return sel;
    endfunction

    assign alloc = (mm5_action == ACT_MISS_ALLOC);
    assign e_alloc = alloc ? find_first(~e_busy) : '0;
    // Counts the entry being taken this cycle as well
    assign flq_full = &(e_busy | e_alloc);

    // Memory side is always granted
    assign e_mem_gnt = find_first(e_mem_req);
    assign mem_req_valid = |e_mem_req;
    assign e_pipe_sel = find_first(e_pipe_req);
    assign e_pipe_gnt = flq_pipe_gnt ? e_pipe_sel : '0;
    assign flq_pipe_req = |e_pipe_req;

    for (genvar e = 0; e < `FLQ_NUM_ENTRIES; e++) begin : g_entries
        assign e_rsp_hit[e] = mem_rsp_valid && (mem_rsp_tag == t_flq_id'(e));
        assign e_fill_done[e] = (mm5_action == ACT_FILL) && (mm5_entry == t_flq_id'(e));
        fillq_entry fillq_entry_inst (
            .clk, .reset,
            .alloc(e_alloc[e]), .alloc_line(mm5_line), .alloc_id(mm5_id),
            .mem_gnt(e_mem_gnt[e]), .mem_rsp_hit(e_rsp_hit[e]), .mem_rsp_data,
            .pipe_gnt(e_pipe_gnt[e]), .fill_done(e_fill_done[e]),
            .busy(e_busy[e]), .line(e_line[e]), .id(e_id[e]), .data(e_data[e]),
            .mem_req(e_mem_req[e]), .pipe_req(e_pipe_req[e])
        );
    end

    always_comb begin
        {mem_req_line, mem_req_tag} = '0;
        {flq_pipe_line, flq_pipe_id, flq_pipe_data, flq_pipe_entry} = '0;
        for (int e = 0; e < `FLQ_NUM_ENTRIES; e++) begin
            if (e_mem_gnt[e]) begin
                mem_req_line = e_line[e];
                mem_req_tag = t_flq_id'(e);
            end
            if (e_pipe_sel[e]) begin
                {flq_pipe_line, flq_pipe_id, flq_pipe_data} = {e_line[e], e_id[e], e_data[e]};
                flq_pipe_entry = t_flq_id'(e);
            end
        end
    end

    // CAM over busy entries plus the one allocating at mm5
    always_comb begin
        cam_mat = alloc && (mm5_line == mm3_line);
        for (int e = 0; e < `FLQ_NUM_ENTRIES; e++) begin
            if (e_busy[e] && e_line[e] == mm3_line) cam_mat = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flq_addr_mat_mm4 <= 1'b0;
        end else begin
            flq_addr_mat_mm4 <= mm3_valid && cam_mat;
        end
    end

endmodule

`default_nettype wire

//--- logic/fillq_entry.sv
`default_nettype none

module fillq_entry
    import mem_common_pkg::*, mem_pipe_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       alloc,
    input  t_line_addr alloc_line,
    input  t_req_id    alloc_id,
    input  logic       mem_gnt,
    input  logic       mem_rsp_hit,
    input  t_word      mem_rsp_data,
    input  logic       pipe_gnt,
    input  logic       fill_done,
    output logic       busy,
    output t_line_addr line,
    output t_req_id    id,
    output t_word      data,
    output logic       mem_req,
    output logic       pipe_req
);

    t_flq_state state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (alloc) state <= MEM_REQ;
                MEM_REQ: if (mem_gnt) state <= MEM_WAIT;
                MEM_WAIT: if (mem_rsp_hit) state <= PIPE_REQ;
                PIPE_REQ: if (pipe_gnt) state <= PIPE_WAIT;
                // Free once the fill has written the array
                PIPE_WAIT: if (fill_done) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc && state == IDLE) begin
            line <= alloc_line;
            id <= alloc_id;
        end
        if (mem_rsp_hit && state == MEM_WAIT) begin
            data <= mem_rsp_data;
        end
    end

    assign busy = (state != IDLE);
    assign mem_req = (state == MEM_REQ);
    assign pipe_req = (state == PIPE_REQ);

endmodule

`default_nettype wire

//--- logic/mem_common_pkg.sv
`default_nettype none

`include "mem_config.svh"

package mem_common_pkg;

    typedef logic [`PADDR_WIDTH-1:0] t_paddr;

    // Address with the byte offset dropped
    typedef logic [`PADDR_WIDTH-`LINE_OFFSET_BITS-1:0] t_line_addr;

    typedef logic [`SET_BITS-1:0] t_set_idx;
    typedef logic [`PADDR_WIDTH-`LINE_OFFSET_BITS-`SET_BITS-1:0] t_tag;

    typedef logic [`REQ_ID_WIDTH-1:0] t_req_id;
    typedef logic [`DATA_WIDTH-1:0] t_word;

endpackage

`default_nettype wire

//--- logic/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Fill queue depth
`define FLQ_NUM_ENTRIES 4

// Address split into tag, set and byte offset
`define PADDR_WIDTH 16
`define LINE_OFFSET_BITS 6
`define SET_BITS 4

`define REQ_ID_WIDTH 4
`define DATA_WIDTH 32

`endif

//--- logic/mem_pipe.sv
`default_nettype none

module mem_pipe
    import mem_common_pkg::*, mem_pipe_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req_valid,
    input  t_paddr     req_addr,
    input  t_req_id    req_id,
    output logic       req_gnt,
    output logic       rsp_valid,
    output logic       rsp_nack,
    output t_req_id    rsp_id,
    output t_word      rsp_data,
    output logic       mem_req_valid,
    output t_line_addr mem_req_line,
    output t_flq_id    mem_req_tag,
    input  logic       mem_rsp_valid,
    input  t_flq_id    mem_rsp_tag,
    input  t_word      mem_rsp_data
);

    logic         flq_pipe_req, flq_pipe_gnt, mm1_valid, mm3_valid;
    logic         flq_addr_mat_mm4, flq_full;
    t_line_addr   flq_pipe_line, mm1_line, mm3_line, mm5_line;
    t_req_id      flq_pipe_id, mm1_id, mm5_id;
    t_word        flq_pipe_data, mm1_data;
    t_flq_id      flq_pipe_entry, mm1_entry, mm5_entry;
    t_arb_type    mm1_type;
    t_pipe_action mm5_action;

    pipe_arb pipe_arb_inst (.*);

    tag_lookup tag_lookup_inst (.*);

    fillq fillq_inst (.*);

endmodule

`default_nettype wire

//--- logic/mem_pipe_pkg.sv
`default_nettype none

`include "mem_config.svh"

package mem_pipe_pkg;

    typedef logic [$clog2(`FLQ_NUM_ENTRIES)-1:0] t_flq_id;

    // What won the mm0 arbitration
    typedef enum logic {
        NEW_REQ,
        FILL
    } t_arb_type;

    // Outcome of an item at mm5
    typedef enum logic [2:0] {
        ACT_NONE,
        ACT_HIT,
        ACT_MISS_ALLOC,
        ACT_NACK,
        ACT_FILL
    } t_pipe_action;

    typedef enum logic [2:0] {
        IDLE,
        MEM_REQ,
        MEM_WAIT,
        PIPE_REQ,
        PIPE_WAIT
    } t_flq_state;

endpackage

`default_nettype wire

//--- logic/pipe_arb.sv
`default_nettype none

`include "mem_config.svh"

module pipe_arb
    import mem_common_pkg::*, mem_pipe_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req_valid,
    input  t_paddr     req_addr,
    input  t_req_id    req_id,
    output logic       req_gnt,
    input  logic       flq_pipe_req,
    input  t_line_addr flq_pipe_line,
    input  t_req_id    flq_pipe_id,
    input  t_word      flq_pipe_data,
    input  t_flq_id    flq_pipe_entry,
    output logic       flq_pipe_gnt,
    output logic       mm1_valid,
    output t_arb_type  mm1_type,
    output t_line_addr mm1_line,
    output t_req_id    mm1_id,
    output t_word      mm1_data,
    output t_flq_id    mm1_entry
);

    logic arb_ready;
    logic new_take;

    // Arbiter opens one cycle after reset is released
    always_ff @(posedge clk) begin
        if (reset) begin
            arb_ready <= 1'b0;
        end else begin
            arb_ready <= 1'b1;
        end
    end

    // Replays always win
    assign flq_pipe_gnt = arb_ready & flq_pipe_req;
    assign req_gnt = arb_ready & ~flq_pipe_req;
    assign new_take = req_valid & req_gnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            mm1_valid <= 1'b0;
        end else begin
            mm1_valid <= flq_pipe_gnt | new_take;
        end
    end

    always_ff @(posedge clk) begin
        if (flq_pipe_gnt) begin
            mm1_type <= FILL;
            mm1_line <= flq_pipe_line;
            mm1_id <= flq_pipe_id;
            mm1_data <= flq_pipe_data;
            mm1_entry <= flq_pipe_entry;
        end else begin
            mm1_type <= NEW_REQ;
            mm1_line <= req_addr[`PADDR_WIDTH-1:`LINE_OFFSET_BITS];
            mm1_id <= req_id;
            mm1_data <= '0;
            mm1_entry <= '0;
        end
    end

endmodule

`default_nettype wire

//--- logic/tag_lookup.sv
`default_nettype none

`include "mem_config.svh"

module tag_lookup
    import mem_common_pkg::*, mem_pipe_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         mm1_valid,
    input  t_arb_type    mm1_type,
    input  t_line_addr   mm1_line,
    input  t_req_id      mm1_id,
    input  t_word        mm1_data,
    input  t_flq_id      mm1_entry,
    input  logic         flq_addr_mat_mm4,
    input  logic         flq_full,
    output logic         mm3_valid,
    output t_line_addr   mm3_line,
    output t_pipe_action mm5_action,
    output t_line_addr   mm5_line,
    output t_req_id      mm5_id,
    output t_flq_id      mm5_entry,
    output logic         rsp_valid,
    output logic         rsp_nack,
    output t_req_id      rsp_id,
    output t_word        rsp_data
);

    localparam int SETS = 1 << `SET_BITS;

    logic         mm2_valid, mm4_valid;
    t_arb_type    mm2_type, mm3_type, mm4_type;
    t_line_addr   mm2_line, mm4_line;
    t_req_id      mm2_id, mm3_id, mm4_id;
    t_word        mm2_data, mm3_data, mm4_data, mm5_data;
    t_flq_id      mm2_entry, mm3_entry, mm4_entry;

    logic [SETS-1:0] valid_arr;
    t_tag         tag_arr [SETS];
    t_word        data_arr [SETS];

    t_set_idx     set4, set5;
    t_tag         tag4, tag5;
    logic         fill_wr, byp_fill, rd_valid, tag_hit, alloc_byp;
    t_tag         rd_tag;
    t_word        rd_data;
    t_pipe_action action_mm4;

    assign set4 = mm4_line[`SET_BITS-1:0];
    assign tag4 = mm4_line[$bits(t_line_addr)-1:`SET_BITS];
    assign set5 = mm5_line[`SET_BITS-1:0];
    assign tag5 = mm5_line[$bits(t_line_addr)-1:`SET_BITS];
    assign fill_wr = (mm5_action == ACT_FILL);

    // Read sees the fill being written at mm5
    assign byp_fill = fill_wr && (set5 == set4);
    assign rd_valid = byp_fill | valid_arr[set4];
    assign rd_tag = byp_fill ? tag5 : tag_arr[set4];
    assign rd_data = byp_fill ? mm5_data : data_arr[set4];
    assign tag_hit = rd_valid && (rd_tag == tag4);

    // Same line allocating right ahead, not yet in the CAM
    assign alloc_byp = (mm5_action == ACT_MISS_ALLOC) && (mm5_line == mm4_line);

    always_comb begin
        if (!mm4_valid) begin
            action_mm4 = ACT_NONE;
        end else if (mm4_type == FILL) begin
            action_mm4 = ACT_FILL;
        end else if (tag_hit) begin
            action_mm4 = ACT_HIT;
        end else if (flq_addr_mat_mm4 || alloc_byp || flq_full) begin
            action_mm4 = ACT_NACK;
        end else begin
            action_mm4 = ACT_MISS_ALLOC;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            {mm2_valid, mm3_valid, mm4_valid} <= '0;
            mm5_action <= ACT_NONE;
            rsp_valid <= 1'b0;
            rsp_nack <= 1'b0;
            valid_arr <= '0;
        end else begin
            {mm2_valid, mm3_valid, mm4_valid} <= {mm1_valid, mm2_valid, mm3_valid};
            mm5_action <= action_mm4;
            rsp_valid <= (action_mm4 == ACT_HIT) || (action_mm4 == ACT_FILL);
            rsp_nack <= (action_mm4 == ACT_NACK);
            if (fill_wr) begin
                valid_arr[set5] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        {mm2_type, mm2_line, mm2_id, mm2_data, mm2_entry} <=
            {mm1_type, mm1_line, mm1_id, mm1_data, mm1_entry};
        {mm3_type, mm3_line, mm3_id, mm3_data, mm3_entry} <=
            {mm2_type, mm2_line, mm2_id, mm2_data, mm2_entry};
        {mm4_type, mm4_line, mm4_id, mm4_data, mm4_entry} <=
            {mm3_type, mm3_line, mm3_id, mm3_data, mm3_entry};
        {mm5_line, mm5_id, mm5_entry} <= {mm4_line, mm4_id, mm4_entry};
        mm5_data <= (mm4_type == FILL) ? mm4_data : rd_data;
        if (fill_wr) begin
            tag_arr[set5] <= tag5;
            data_arr[set5] <= mm5_data;
        end
    end

    assign rsp_id = mm5_id;
    assign rsp_data = mm5_data;

endmodule

`default_nettype wire

//--- mem_pipe.f
+incdir+logic
logic/mem_common_pkg.sv
logic/mem_pipe_pkg.sv
logic/pipe_arb.sv
logic/tag_lookup.sv
logic/fillq_entry.sv
logic/fillq.sv
logic/mem_pipe.sv
bench/mem_pipe_asserts.sv
bench/mem_pipe_checker.sv
bench/mem_pipe_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mem_pipe.f \
    --top-module mem_pipe_tb -o mem_pipe_sim
./obj_dir/mem_pipe_sim > sim.log
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
    exit 0
else
    echo "simulation did not report a pass"
    exit 1
fi
